//--- hdl/branch_predictor.sv
`include "fetch_consts.svh"

module branch_predictor (
    input  logic                                 clock,
    input  logic                                 reset,
    input  isa_pkg::addr_t [`FETCH_WIDTH-1:0]    pcs,
    output logic           [`FETCH_WIDTH-1:0]    pred_taken,
    // training from branch resolution
    input  logic                                 update_valid,
    input  isa_pkg::addr_t                       update_pc,
    input  logic                                 update_taken
);
    import fetch_pkg::*;

    ctr_t    ctr_table [`BP_ENTRIES];
    bp_idx_t upd_idx;
    ctr_t    upd_ctr;                        // counter being trained

    always_comb begin
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            pred_taken[i] = (ctr_table[bp_idx_t'(pcs[i] >> 2)] >= ctr_weak_taken);
        end
    end

    assign upd_idx = bp_idx_t'(update_pc >> 2);
    assign upd_ctr = ctr_table[upd_idx];

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int e = 0; e < `BP_ENTRIES; e++) begin
                ctr_table[e] <= ctr_weak_not_taken;
            end
        end else if (update_valid) begin
            if (update_taken && (upd_ctr != 2'd3)) begin
                ctr_table[upd_idx] <= upd_ctr + 2'd1;  // saturates at 3
            end else if (!update_taken && (upd_ctr != 2'd0)) begin
                ctr_table[upd_idx] <= upd_ctr - 2'd1;  // saturates at 0
            end
        end
    end

endmodule

//--- hdl/btb.sv
`include "fetch_consts.svh"

module btb (
    input  logic                                 clock,
    input  logic                                 reset,
    input  isa_pkg::addr_t [`FETCH_WIDTH-1:0]    pcs,
    output logic           [`FETCH_WIDTH-1:0]    btb_hit,
    output isa_pkg::addr_t [`FETCH_WIDTH-1:0]    btb_target,
    // only taken updates allocate
    input  logic                                 update_valid,
    input  isa_pkg::addr_t                       update_pc,
    input  logic                                 update_taken,
    input  isa_pkg::addr_t                       update_target
);
    import isa_pkg::*;
    import fetch_pkg::*;

    logic     entry_valid  [`BTB_ENTRIES];
    addr_t    entry_tag    [`BTB_ENTRIES];   // full pc, no aliasing
    addr_t    entry_target [`BTB_ENTRIES];
    btb_idx_t lane_idx     [`FETCH_WIDTH];
    btb_idx_t upd_idx;
    logic     upd_write;

    always_comb begin
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            lane_idx[i]   = btb_idx_t'(pcs[i] >> 2);
            btb_hit[i]    = entry_valid[lane_idx[i]] && (entry_tag[lane_idx[i]] == pcs[i]);
            btb_target[i] = entry_target[lane_idx[i]];
        end
    end

    assign upd_idx   = btb_idx_t'(update_pc >> 2);
    assign upd_write = update_valid && update_taken;

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int e = 0; e < `BTB_ENTRIES; e++) begin
                entry_valid[e] <= 1'b0;
            end
        end else if (upd_write) begin
            entry_valid[upd_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (upd_write) begin
            entry_tag[upd_idx]    <= update_pc;
            entry_target[upd_idx] <= update_target;  // last taken target wins
        end
    end

endmodule

//--- hdl/fetch.sv
`include "fetch_consts.svh"

module fetch (
    input  logic                                 clock,
    input  logic                                 reset,
    // lane addresses out to icache, predictor and btb
    output isa_pkg::addr_t [`FETCH_WIDTH-1:0]    pcs,
    input  logic           [`FETCH_WIDTH-1:0]    pcs_hit,
    input  isa_pkg::inst_t [`FETCH_WIDTH-1:0]    pcs_inst,
    input  logic           [`FETCH_WIDTH-1:0]    pred_taken,
    input  logic           [`FETCH_WIDTH-1:0]    btb_hit,
    input  isa_pkg::addr_t [`FETCH_WIDTH-1:0]    btb_target,
    // redirect from the branch stack
    input  logic                                 restore,
    input  isa_pkg::addr_t                       restore_pc,
    // buffer handshake, room in and lanes out
    input  fetch_pkg::lane_count_t               slots,
    output fetch_pkg::lane_count_t               write_count,
    output isa_pkg::addr_t [`FETCH_WIDTH-1:0]    wr_pc,
    output isa_pkg::inst_t [`FETCH_WIDTH-1:0]    wr_inst,
    output logic           [`FETCH_WIDTH-1:0]    wr_taken,
    output isa_pkg::addr_t [`FETCH_WIDTH-1:0]    wr_target
);
    import isa_pkg::*;
    import fetch_pkg::*;

    addr_t pc_q;                             // pc of lane 0
    addr_t pc_next;
    logic  group_done;                       // set once a lane stops the group
    logic  [`FETCH_WIDTH-1:0] lane_cti;      // branch, jal or jalr
    opcode_t lane_op [`FETCH_WIDTH];

    always_comb begin
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            pcs[i] = pc_q + addr_t'(4 * i);  // consecutive words
        end
    end

    // lane rule and next pc in one pass, lane 0 upward
    always_comb begin
        pc_next     = pc_q;                  // hold when nothing is written
        write_count = '0;
        group_done  = restore;               // restore cycle writes no lanes
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            lane_op[i]   = opcode_t'(pcs_inst[i][6:0]);
            lane_cti[i]  = (lane_op[i] == op_branch) || (lane_op[i] == op_jal)
                        || (lane_op[i] == op_jalr);
            wr_pc[i]     = pcs[i];
            wr_inst[i]   = pcs_inst[i];
            wr_taken[i]  = 1'b0;
            wr_target[i] = pcs[i] + addr_t'(4);  // fall through by default
            if (!group_done && (i < int'(slots)) && pcs_hit[i]) begin
                write_count = lane_count_t'(i + 1);
                if (lane_cti[i] && pred_taken[i] && btb_hit[i]) begin
                    wr_taken[i]  = 1'b1;
                    wr_target[i] = btb_target[i];
                    group_done   = 1'b1;     // nothing after a taken branch
                end
                pc_next = wr_target[i];      // last written lane decides
            end else begin
                group_done = 1'b1;           // miss or no room, stop in order
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            pc_q <= '0;                      // program starts at 0
        end else if (restore) begin
            pc_q <= restore_pc;
        end else begin
            pc_q <= pc_next;
        end
    end

endmodule

//--- hdl/fetch_consts.svh
`ifndef FETCH_CONSTS_SVH
`define FETCH_CONSTS_SVH

// lanes fetched per cycle, consecutive words
`define FETCH_WIDTH 2

// instruction buffer entries, power of two so pointers wrap by themselves
`define IBUF_DEPTH 8

// bimodal predictor, indexed by pc[5:2]
`define BP_ENTRIES 16

// branch target buffer, indexed by pc[4:2], full pc kept as tag
`define BTB_ENTRIES 8

// direct-mapped icache with one word per line, indexed by pc[5:2]
`define ICACHE_LINES 16

`endif

//--- hdl/fetch_pkg.sv
`include "fetch_consts.svh"

package fetch_pkg;

    typedef logic [$clog2(`FETCH_WIDTH+1)-1:0] lane_count_t;  // 0 .. FETCH_WIDTH

    typedef logic [1:0] ctr_t;                                // saturating counter
    localparam ctr_t ctr_weak_not_taken = 2'd1;               // reset value
    localparam ctr_t ctr_weak_taken     = 2'd2;               // predict taken at or above

    typedef logic [$clog2(`BP_ENTRIES)-1:0]   bp_idx_t;
    typedef logic [$clog2(`BTB_ENTRIES)-1:0]  btb_idx_t;
    typedef logic [$clog2(`ICACHE_LINES)-1:0] line_idx_t;
    typedef logic [$clog2(`IBUF_DEPTH)-1:0]   ibuf_ptr_t;
    typedef logic [$clog2(`IBUF_DEPTH+1)-1:0] ibuf_count_t;  // 0 .. IBUF_DEPTH

    typedef enum logic [1:0] {fill_idle, fill_req, fill_wait_drop} fill_state_t;

    typedef enum logic [1:0] {drain_idle, drain_req, drain_wait_drop} drain_state_t;

endpackage

//--- hdl/fetch_top.sv
`include "fetch_consts.svh"

module fetch_top (
    input  logic           clock,
    input  logic           reset,
    // branch stack redirect
    input  logic           restore,
    input  isa_pkg::addr_t restore_pc,
    // instruction memory refill
    output logic           mem_req,
    output isa_pkg::addr_t mem_addr,
    input  logic           mem_ack,
    input  isa_pkg::inst_t mem_data,
    // buffer drain to decode
    output logic           out_req,
    input  logic           out_ack,
    output isa_pkg::addr_t out_pc,
    output isa_pkg::inst_t out_inst,
    output logic           out_taken,
    output isa_pkg::addr_t out_target,
    // predictor and btb training
    input  logic           update_valid,
    input  isa_pkg::addr_t update_pc,
    input  logic           update_taken,
    input  isa_pkg::addr_t update_target
);
    import isa_pkg::*;
    import fetch_pkg::*;

    addr_t [`FETCH_WIDTH-1:0] pcs;           // shared lookup address per lane
    logic  [`FETCH_WIDTH-1:0] hit;
    inst_t [`FETCH_WIDTH-1:0] inst;
    logic  [`FETCH_WIDTH-1:0] pred_taken;
    logic  [`FETCH_WIDTH-1:0] btb_hit;
    addr_t [`FETCH_WIDTH-1:0] btb_target;
    lane_count_t              slots;
    lane_count_t              write_count;
    addr_t [`FETCH_WIDTH-1:0] wr_pc;
    inst_t [`FETCH_WIDTH-1:0] wr_inst;
    logic  [`FETCH_WIDTH-1:0] wr_taken;
    addr_t [`FETCH_WIDTH-1:0] wr_target;

    fetch fetch_i (
        .clock, .reset, .pcs, .pcs_hit(hit), .pcs_inst(inst), .pred_taken, .btb_hit,
        .btb_target, .restore, .restore_pc, .slots, .write_count, .wr_pc, .wr_inst,
        .wr_taken, .wr_target
    );

    icache icache_i (
        .clock, .reset, .pcs, .hit, .inst, .mem_req, .mem_addr, .mem_ack, .mem_data
    );

    branch_predictor bp_i (
        .clock, .reset, .pcs, .pred_taken, .update_valid, .update_pc, .update_taken
    );

    btb btb_i (
        .clock, .reset, .pcs, .btb_hit, .btb_target, .update_valid, .update_pc,
        .update_taken, .update_target
    );

    // restore doubles as the buffer flush
    inst_buffer ibuf_i (
        .clock, .reset, .flush(restore), .slots, .write_count, .wr_pc, .wr_inst, .wr_taken,
        .wr_target, .out_req, .out_ack, .out_pc, .out_inst, .out_taken, .out_target
    );

endmodule

//--- hdl/icache.sv
`include "fetch_consts.svh"

module icache (
    input  logic                                 clock,
    input  logic                                 reset,
    input  isa_pkg::addr_t [`FETCH_WIDTH-1:0]    pcs,       // one lookup per lane
    output logic           [`FETCH_WIDTH-1:0]    hit,
    output isa_pkg::inst_t [`FETCH_WIDTH-1:0]    inst,
    // refill port, four-phase req/ack
    output logic                                 mem_req,
    output isa_pkg::addr_t                       mem_addr,
    input  logic                                 mem_ack,
    input  isa_pkg::inst_t                       mem_data
);
    import isa_pkg::*;
    import fetch_pkg::*;

    localparam int tag_lsb  = $bits(line_idx_t) + 2;     // above index and byte offset
    localparam int tag_bits = $bits(addr_t) - tag_lsb;

    logic                line_valid [`ICACHE_LINES];
    logic [tag_bits-1:0] line_tag   [`ICACHE_LINES];
    inst_t               line_data  [`ICACHE_LINES];

    line_idx_t   lane_idx [`FETCH_WIDTH];
    logic        miss_found;                 // some lane missed this cycle
    addr_t       miss_addr;                  // lowest missing lane
    fill_state_t fill_state;
    addr_t       fill_addr;
    line_idx_t   fill_idx;
    logic        fill_done;

    // lookups
    always_comb begin
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            lane_idx[i] = line_idx_t'(pcs[i] >> 2);
            hit[i]      = line_valid[lane_idx[i]]
                       && (line_tag[lane_idx[i]] == pcs[i][$bits(addr_t)-1:tag_lsb]);
            inst[i]     = line_data[lane_idx[i]];
        end
    end

    always_comb begin
        miss_found = 1'b0;
        miss_addr  = pcs[0];
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            if (!hit[i] && !miss_found) begin
                miss_found = 1'b1;
                miss_addr  = pcs[i];
            end
        end
    end

    assign fill_idx  = line_idx_t'(fill_addr >> 2);
    assign fill_done = (fill_state == fill_req) && mem_ack;  // data valid with ack
    assign mem_req   = (fill_state == fill_req);
    assign mem_addr  = fill_addr;

    always_ff @(posedge clock) begin
        if (reset) begin
            fill_state <= fill_idle;
        end else begin
            case (fill_state)
                fill_idle:      if (miss_found) fill_state <= fill_req;
                fill_req:       if (mem_ack) fill_state <= fill_wait_drop;
                fill_wait_drop: if (!mem_ack) fill_state <= fill_idle;  // phase 4 done
                default:        fill_state <= fill_idle;
            endcase
        end
    end

    // address is held for the whole request
    always_ff @(posedge clock) begin
        if ((fill_state == fill_idle) && miss_found) begin
            fill_addr <= miss_addr;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int l = 0; l < `ICACHE_LINES; l++) begin
                line_valid[l] <= 1'b0;
            end
        end else if (fill_done) begin
            line_valid[fill_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (fill_done) begin
            line_tag[fill_idx]  <= fill_addr[$bits(addr_t)-1:tag_lsb];
            line_data[fill_idx] <= mem_data;
        end
    end

endmodule

//--- hdl/inst_buffer.sv
`include "fetch_consts.svh"

module inst_buffer (
    input  logic                                 clock,
    input  logic                                 reset,
    input  logic                                 flush,       // restore empties everything
    // write side, from fetch
    output fetch_pkg::lane_count_t               slots,
    input  fetch_pkg::lane_count_t               write_count,
    input  isa_pkg::addr_t [`FETCH_WIDTH-1:0]    wr_pc,
    input  isa_pkg::inst_t [`FETCH_WIDTH-1:0]    wr_inst,
    input  logic           [`FETCH_WIDTH-1:0]    wr_taken,
    input  isa_pkg::addr_t [`FETCH_WIDTH-1:0]    wr_target,
    // drain side, four-phase req/ack
    output logic                                 out_req,
    input  logic                                 out_ack,
    output isa_pkg::addr_t                       out_pc,
    output isa_pkg::inst_t                       out_inst,
    output logic                                 out_taken,
    output isa_pkg::addr_t                       out_target
);
    import isa_pkg::*;
    import fetch_pkg::*;

    addr_t pc_mem     [`IBUF_DEPTH];
    inst_t inst_mem   [`IBUF_DEPTH];
    logic  taken_mem  [`IBUF_DEPTH];
    addr_t target_mem [`IBUF_DEPTH];

    ibuf_ptr_t    head;
    ibuf_ptr_t    tail;
    ibuf_count_t  count;
    ibuf_count_t  free_cnt;
    ibuf_ptr_t    wr_ptr [`FETCH_WIDTH];
    drain_state_t drain_state;
    logic         pop;

    assign free_cnt = ibuf_count_t'(`IBUF_DEPTH) - count;
    assign slots    = (int'(free_cnt) >= `FETCH_WIDTH) ? lane_count_t'(`FETCH_WIDTH)
                                                       : lane_count_t'(free_cnt);
    assign pop      = (drain_state == drain_req) && out_ack;  // phase 3

    always_comb begin
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            wr_ptr[i] = tail + ibuf_ptr_t'(i);     // wraps at depth
        end
    end

    always_ff @(posedge clock) begin
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            if (i < int'(write_count)) begin
                pc_mem[wr_ptr[i]]     <= wr_pc[i];
                inst_mem[wr_ptr[i]]   <= wr_inst[i];
                taken_mem[wr_ptr[i]]  <= wr_taken[i];
                target_mem[wr_ptr[i]] <= wr_target[i];
            end
        end
    end

    // pointers, count and drain fsm
    always_ff @(posedge clock) begin
        if (reset || flush) begin
            head        <= '0;
            tail        <= '0;
            count       <= '0;
            drain_state <= drain_idle;               // waits in idle for ack to fall
        end else begin
            tail  <= tail + ibuf_ptr_t'(write_count);
            head  <= head + ibuf_ptr_t'(pop);
            count <= count + ibuf_count_t'(write_count) - ibuf_count_t'(pop);
            case (drain_state)
                drain_idle:      if ((count != '0) && !out_ack) drain_state <= drain_req;
                drain_req:       if (out_ack) drain_state <= drain_wait_drop;
                drain_wait_drop: if (!out_ack) drain_state <= drain_idle;
                default:         drain_state <= drain_idle;
            endcase
        end
    end

    assign out_req    = (drain_state == drain_req);
    assign out_pc     = pc_mem[head];                // head entry, stable while req is up
    assign out_inst   = inst_mem[head];
    assign out_taken  = taken_mem[head];
    assign out_target = target_mem[head];

endmodule

//--- hdl/isa_pkg.sv
package isa_pkg;

    // byte address, always word aligned in this front end
    typedef logic [31:0] addr_t;

    // raw 32-bit instruction word
    typedef logic [31:0] inst_t;

    // major opcode, inst[6:0]
    typedef logic [6:0] opcode_t;

    // control-transfer opcodes, rv32i encodings
    localparam opcode_t op_branch = 7'b1100011;  // beq, bne, blt ...
    localparam opcode_t op_jal    = 7'b1101111;  // pc-relative jump
    localparam opcode_t op_jalr   = 7'b1100111;  // register-indirect jump

    // other opcodes are never looked at by fetch
    //   everything that is not one of the three above
    //   flows through as a plain sequential instruction

endpackage

//--- run_sim.sh
#!/usr/bin/env bash
# build the fetch testbench with verilator, run it, and judge the output

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -f sources.f --top-module fetch_tb -Mdir obj_dir; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vfetch_tb)
status=$?
printf '%s\n' "$output"

if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "all tests passed" <<< "$output"; then
    exit 0
else
    exit 1
fi

//--- sources.f
+incdir+hdl
+incdir+tb
hdl/isa_pkg.sv
hdl/fetch_pkg.sv
hdl/fetch.sv
hdl/icache.sv
hdl/branch_predictor.sv
hdl/btb.sv
hdl/inst_buffer.sv
hdl/fetch_top.sv
tb/fetch_tb.sv

//--- tb/fetch_model.svh
`ifndef FETCH_MODEL_SVH
`define FETCH_MODEL_SVH

inst_t prog_mem     [256];                   // program image, indexed by pc[9:2]
ctr_t  model_ctr    [`BP_ENTRIES];           // bimodal counters, pc[5:2]
logic  model_valid  [`BTB_ENTRIES];          // btb entries, pc[4:2]
addr_t model_tag    [`BTB_ENTRIES];
addr_t model_target [`BTB_ENTRIES];

task automatic clear_model();
    for (int e = 0; e < `BP_ENTRIES; e++) begin
        model_ctr[e] = 2'd1;                 // weakly not taken
    end
    for (int e = 0; e < `BTB_ENTRIES; e++) begin
        model_valid[e]  = 1'b0;
        model_tag[e]    = '0;
        model_target[e] = '0;
    end
endtask

// one saturating step toward the outcome, btb written on taken only
task automatic train_model(input addr_t pc, input logic taken, input addr_t target);
    if (taken && (model_ctr[pc[5:2]] != 2'd3)) begin
        model_ctr[pc[5:2]] = model_ctr[pc[5:2]] + 2'd1;
    end else if (!taken && (model_ctr[pc[5:2]] != 2'd0)) begin
        model_ctr[pc[5:2]] = model_ctr[pc[5:2]] - 2'd1;
    end
    if (taken) begin
        model_valid[pc[4:2]]  = 1'b1;
        model_tag[pc[4:2]]    = pc;
        model_target[pc[4:2]] = target;
    end
endtask

function automatic logic is_cti(inst_t w);
    return (w[6:0] == op_branch) || (w[6:0] == op_jal) || (w[6:0] == op_jalr);
endfunction

function automatic logic expect_taken(addr_t pc);
    return is_cti(prog_mem[pc[9:2]]) && (model_ctr[pc[5:2]] >= 2'd2)
        && model_valid[pc[4:2]] && (model_tag[pc[4:2]] == pc);
endfunction

function automatic addr_t expect_target(addr_t pc);
    return expect_taken(pc) ? model_target[pc[4:2]] : pc + 32'd4;
endfunction

task automatic check_inst(input string name, input inst_t got, input inst_t exp);
    if (got !== exp) begin
        mismatch_count++;
        $display("MISMATCH %s: got %h, expected %h", name, got, exp);
    end
endtask

task automatic check_addr(input string name, input addr_t got, input addr_t exp);
    if (got !== exp) begin
        mismatch_count++;
        $display("MISMATCH %s: got %h, expected %h", name, got, exp);
    end
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        mismatch_count++;
        $display("MISMATCH %s: got %h, expected %h", name, got, exp);
    end
endtask

`endif

//--- tb/fetch_tb.sv
`include "fetch_consts.svh"

module fetch_tb;
    import isa_pkg::*;
    import fetch_pkg::*;

    localparam int phase_count  = 8;
    localparam int drain_count  = 40;        // entries checked per phase
    localparam int update_count = 12;
    localparam int wait_limit   = 200;       // cycles before a wait gives up

    logic  clock = 1'b0;
    logic  reset = 1'b1;
    logic  restore = 1'b0;
    addr_t restore_pc = '0;
    logic  mem_req;
    addr_t mem_addr;
    logic  mem_ack = 1'b0;
    inst_t mem_data = '0;
    logic  out_req;
    logic  out_ack = 1'b0;
    addr_t out_pc;
    inst_t out_inst;
    logic  out_taken;
    addr_t out_target;
    logic  update_valid = 1'b0;
    addr_t update_pc = '0;
    logic  update_taken = 1'b0;
    addr_t update_target = '0;

    int          mismatch_count = 0;
    int          timeout_count = 0;      // main process only
    int          resp_timeouts = 0;      // memory responder only
    logic [31:0] main_state = 32'd89519;
    logic [31:0] resp_state = 32'd89519; // lcg stream of the memory responder
    logic        resp_counting = 1'b0;
    int          resp_wait = 0;
    int          resp_hold = 0;
    addr_t       resp_addr = '0;         // mem_addr seen when the request came up

    `include "fetch_model.svh"

    fetch_top dut_i (
        .clock, .reset, .restore, .restore_pc, .mem_req, .mem_addr, .mem_ack, .mem_data,
        .out_req, .out_ack, .out_pc, .out_inst, .out_taken, .out_target,
        .update_valid, .update_pc, .update_taken, .update_target
    );

    always #5 clock = ~clock;

    function automatic logic [31:0] lcg_next(logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic next_rand(input int unsigned range, output int unsigned value);
        main_state = lcg_next(main_state);
        value = {16'd0, main_state[31:16]} % range;  // low bits of an lcg cycle fast
    endtask

    function automatic addr_t word_addr(int unsigned idx);
        return {22'd0, idx[7:0], 2'b00};
    endfunction

    // about one word in four is a control transfer
    task automatic build_program();
        int unsigned sel;
        opcode_t     op;
        for (int a = 0; a < 256; a++) begin
            main_state = lcg_next(main_state);
            next_rand(12, sel);
            case (sel)
                0:       op = op_branch;
                1:       op = op_jal;
                2:       op = op_jalr;
                default: op = 7'b0010011;    // op-imm falls through as plain sequential
            endcase
            prog_mem[a] = {main_state[31:7], op};
        end
    endtask

    // four-phase memory acking after 1 to 4 cycles
    always @(negedge clock) begin
        if (reset) begin
            mem_ack = 1'b0;
            resp_counting = 1'b0;
        end else if (mem_req && !mem_ack) begin
            if (!resp_counting) begin
                resp_state = lcg_next(resp_state);
                resp_wait = 1 + int'(resp_state[25:24]);
                resp_counting = 1'b1;
                resp_addr = mem_addr;
            end
            check_addr("mem_addr", mem_addr, resp_addr);  // held until the ack
            resp_wait--;
            if (resp_wait == 0) begin
                mem_data = prog_mem[mem_addr[9:2]];
                mem_ack = 1'b1;
                resp_counting = 1'b0;
                resp_hold = 0;
            end
        end else if (mem_ack && !mem_req) begin
            mem_ack = 1'b0;                  // phase 4
        end else if (mem_ack) begin
            resp_hold++;
            if (resp_hold == wait_limit) begin
                $display("timeout: the cache kept mem_req high long after mem_ack");
                resp_timeouts++;
            end
        end
    end

    // one four-phase pop checked against the path the model expects
    task automatic drain_entry(inout addr_t exp_pc);
        int          waited;
        int unsigned r;
        int unsigned stall;
        addr_t       exp_target;
        waited = 0;
        while (!out_req && waited < wait_limit) begin
            @(negedge clock);
            waited++;
        end
        if (!out_req) begin
            $display("timeout: the buffer raised no out_req within %0d cycles", wait_limit);
            timeout_count++;
        end else begin
            exp_target = expect_target(exp_pc);
            check_addr("out_pc", out_pc, exp_pc);
            check_inst("out_inst", out_inst, prog_mem[exp_pc[9:2]]);
            check_flag("out_taken", out_taken, expect_taken(exp_pc));
            check_addr("out_target", out_target, exp_target);
            exp_pc = exp_target;             // next entry follows this target
            next_rand(6, r);
            if (r == 0) begin
                next_rand(16, stall);
                stall = stall + 15;          // long stall lets the buffer fill up
            end else begin
                next_rand(4, stall);
            end
            repeat (stall) @(negedge clock);
            out_ack = 1'b1;
            waited = 0;
            @(negedge clock);
            while (out_req && waited < wait_limit) begin
                @(negedge clock);
                waited++;
            end
            if (out_req) begin
                $display("timeout: out_req stayed high after out_ack was raised");
                timeout_count++;
            end
            out_ack = 1'b0;
        end
    endtask

    // train, redirect, then drain with the tables held still
    task automatic run_phase();
        int unsigned base;
        int unsigned r;
        addr_t       exp_pc;
        next_rand(240, base);                // window of 16 words stays inside the image
        for (int u = 0; u < update_count; u++) begin
            @(negedge clock);
            next_rand(16, r);
            update_valid = 1'b1;
            update_pc = word_addr(base + r);
            next_rand(4, r);
            update_taken = (r != 0);
            next_rand(256, r);
            update_target = word_addr(r);
            train_model(update_pc, update_taken, update_target);
        end
        @(negedge clock);
        update_valid = 1'b0;
        restore = 1'b1;
        restore_pc = word_addr(base);
        @(negedge clock);
        restore = 1'b0;
        exp_pc = restore_pc;                 // first entry after restore
        for (int n = 0; n < drain_count && timeout_count == 0; n++) begin
            drain_entry(exp_pc);
        end
    endtask

    initial begin
        build_program();
        clear_model();
        repeat (16) @(posedge clock);
        @(negedge clock);
        check_flag("mem_req", mem_req, 1'b0);
        check_flag("out_req", out_req, 1'b0);
        reset = 1'b0;
        for (int p = 0; p < phase_count && timeout_count == 0; p++) begin
            run_phase();
        end
        $display("%0d mismatches, %0d timeouts", mismatch_count,
                 timeout_count + resp_timeouts);
        if (mismatch_count == 0 && timeout_count == 0 && resp_timeouts == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule
